//--- sifhPkg.sv
/*
 * Shared sizes and derived widths of the SiFH peak finder
 * Frame organisation, histogram storage and pass encoding
 */
package sifhPkg;

    //**************************************************
    // Sample and bin geometry
    //**************************************************
    localparam int SAMPLE_W      = 10;                         // Detector sample width
    localparam int BIN_W         = 6;                          // Bin address width
    localparam int BIN_NUM       = 1 << BIN_W;                 // Bins per pixel histogram
    localparam int COARSE_SHIFT  = SAMPLE_W - BIN_W;           // Coarse bin is 16 codes
    localparam int WINDOW_MARGIN = 24;                         // Window start below coarse bin
    localparam int WINDOW_MAX    = (1 << SAMPLE_W) - BIN_NUM;  // Top window low edge, 960

    //**************************************************
    // Frame organisation
    //**************************************************
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W   = $clog2(PIXEL_NUM);
    localparam int DATA_NUM  = 4;                  // Samples per pixel per acquisition
    localparam int DATA_W    = $clog2(DATA_NUM);
    localparam int ACQ_NUM   = 8;                  // Acquisitions per pass
    localparam int ACQ_W     = $clog2(ACQ_NUM);

    // Histogram storage
    localparam int COUNT_W   = 6;                  // Up to 32 hits per pixel per pass
    localparam int BIN_TOTAL = PIXEL_NUM * BIN_NUM;
    localparam int BIN_IDX_W = $clog2(BIN_TOTAL);  // Pixel and bin concatenated

    // Pass encoding
    localparam logic PASS_COARSE = 1'b0;
    localparam logic PASS_FINE   = 1'b1;

endpackage

//--- frameControl.sv
/*
 * Frame sequencer of the peak finder
 * Four-phase sample and result handshakes, nested sample counters,
 * pipeline drain and pass end pulse
 */
module frameControl import sifhPkg::*; (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               sampleReq,
    output logic               sampleAck,
    output logic               resultReq,
    input  logic               resultAck,
    output logic               sampleTake,
    output logic [PIXEL_W-1:0] pixelIdx,
    output logic               pass,
    output logic               passEnd,
    output logic [PIXEL_W-1:0] resultPixel
);

    typedef enum logic [1:0] {
        SAMPLING,
        DRAINING,
        RESULTS
    } phaseType;

    phaseType          phase;
    logic [DATA_W-1:0] inputCount;   // Sample within burst
    logic [ACQ_W-1:0]  acqCount;     // Acquisition within pass
    logic [1:0]        drainCount;
    logic              resultDone;   // Current pixel acknowledged
    logic              lastSample;

    // Fresh request while sampling
    assign sampleTake = (phase == SAMPLING) && sampleReq && !sampleAck;
    assign lastSample = (inputCount == DATA_W'(DATA_NUM - 1)) &&
                        (pixelIdx == PIXEL_W'(PIXEL_NUM - 1)) &&
                        (acqCount == ACQ_W'(ACQ_NUM - 1));

    //**************************************************
    // Input handshake
    //**************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleAck <= 1'b0;
        end else if (sampleAck && !sampleReq) begin
            sampleAck <= 1'b0;                       // Return to zero
        end else if (sampleTake) begin
            sampleAck <= 1'b1;
        end
    end

    //**************************************************
    // Phase FSM with counters
    //**************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            phase       <= SAMPLING;
            pass        <= PASS_COARSE;
            inputCount  <= '0;
            pixelIdx    <= '0;
            acqCount    <= '0;
            drainCount  <= '0;
            passEnd     <= 1'b0;
            resultReq   <= 1'b0;
            resultPixel <= '0;
            resultDone  <= 1'b0;
        end else begin
            case (phase)
                SAMPLING: begin
                    if (sampleTake) begin
                        if (inputCount < DATA_W'(DATA_NUM - 1)) begin
                            inputCount <= inputCount + 1'b1;
                        end else begin
                            inputCount <= '0;
                            if (pixelIdx < PIXEL_W'(PIXEL_NUM - 1)) begin
                                pixelIdx <= pixelIdx + 1'b1;
                            end else begin
                                pixelIdx <= '0;
                                if (acqCount < ACQ_W'(ACQ_NUM - 1)) begin
                                    acqCount <= acqCount + 1'b1;
                                end else begin
                                    acqCount <= '0;   // Pass complete
                                end
                            end
                        end
                        if (lastSample) begin
                            phase <= DRAINING;
                        end
                    end
                end
                DRAINING: begin
                    // Filter, histogram and tracker stages empty out first
                    case (drainCount)
                        2'd0: drainCount <= 2'd1;
                        2'd1: begin
                            passEnd    <= 1'b1;          // Tracker holds last update
                            drainCount <= 2'd2;
                        end
                        2'd2: begin
                            passEnd    <= 1'b0;
                            pass       <= (pass == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
                            drainCount <= 2'd3;
                        end
                        default: begin
                            if (!sampleAck) begin            // Last input ack released
                                drainCount  <= 2'd0;
                                resultPixel <= '0;
                                resultDone  <= 1'b0;
                                phase       <= (pass == PASS_FINE) ? SAMPLING : RESULTS;
                            end
                        end
                    endcase
                end
                RESULTS: begin
                    if (resultReq) begin
                        if (resultAck) begin
                            resultReq  <= 1'b0;
                            resultDone <= 1'b1;
                        end
                    end else if (!resultAck) begin
                        if (!resultDone) begin
                            resultReq <= 1'b1;               // Present current pixel
                        end else if (resultPixel == PIXEL_W'(PIXEL_NUM - 1)) begin
                            resultPixel <= '0;               // Frame done, next is coarse
                            resultDone  <= 1'b0;
                            phase       <= SAMPLING;
                        end else begin
                            resultPixel <= resultPixel + 1'b1;
                            resultDone  <= 1'b0;
                        end
                    end
                end
                default: phase <= SAMPLING;
            endcase
        end
    end

endmodule

//--- sampleFilter.sv
/*
 * Sample filter
 * Coarse pass takes top bits, fine pass keeps the 64-code window
 */
module sampleFilter import sifhPkg::*; (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                sampleTake,
    input  logic [SAMPLE_W-1:0] sample,
    input  logic [PIXEL_W-1:0]  pixelIdx,
    input  logic                pass,
    input  logic [SAMPLE_W-1:0] winLow,
    output logic                binStrobe,
    output logic [BIN_W-1:0]    binAddr,
    output logic [PIXEL_W-1:0]  binPixel
);

    logic [SAMPLE_W-1:0] offset;     // Sample minus delta
    logic                inWindow;
    logic                keep;
    logic [BIN_W-1:0]    nextAddr;

    assign offset   = sample - winLow;
    assign inWindow = (sample >= winLow) && (offset < SAMPLE_W'(BIN_NUM));  // winLow..winLow+63
    assign keep     = (pass == PASS_COARSE) || inWindow;
    assign nextAddr = (pass == PASS_COARSE) ? sample[SAMPLE_W-1:COARSE_SHIFT]
                                            : offset[BIN_W-1:0];

    // Strobe is dropped for discarded samples
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binStrobe <= 1'b0;
        end else begin
            binStrobe <= sampleTake && keep;
        end
    end

    always_ff @(posedge clk) begin
        if (sampleTake) begin
            binAddr  <= nextAddr;
            binPixel <= pixelIdx;    // Counter moves on this edge
        end
    end

endmodule

//--- histogramRam.sv
/*
 * Histogram bin counters for all pixels
 * Per-bin valid bits replace clearing the counters
 */
module histogramRam import sifhPkg::*; (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               binStrobe,
    input  logic [BIN_W-1:0]   binAddr,
    input  logic [PIXEL_W-1:0] binPixel,
    input  logic               passEnd,
    output logic               countStrobe,
    output logic [COUNT_W-1:0] countValue,
    output logic [BIN_W-1:0]   countAddr,
    output logic [PIXEL_W-1:0] countPixel
);

    //**************************************************
    // Storage
    //**************************************************
    logic [COUNT_W-1:0]   binCount [BIN_TOTAL];
    logic [BIN_TOTAL-1:0] binValid;              // 0 means stale from last pass
    logic [BIN_IDX_W-1:0] binIndex;
    logic [COUNT_W-1:0]   nextCount;

    assign binIndex  = {binPixel, binAddr};      // Pixel selects 64-bin region
    assign nextCount = binValid[binIndex] ? binCount[binIndex] + 1'b1
                                          : COUNT_W'(1);   // Stale bin restarts

    // Valid bits and strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid    <= '0;
            countStrobe <= 1'b0;
        end else begin
            countStrobe <= binStrobe;
            if (passEnd) begin
                binValid <= '0;                  // Whole histogram invalid at once
            end else if (binStrobe) begin
                binValid[binIndex] <= 1'b1;
            end
        end
    end

    // Read-modify-write of the addressed counter
    always_ff @(posedge clk) begin
        if (binStrobe) begin
            binCount[binIndex] <= nextCount;
            countValue         <= nextCount;
            countAddr          <= binAddr;
            countPixel         <= binPixel;
        end
    end

endmodule

//--- peakTracker.sv
/*
 * Per-pixel peak tracker
 * Running maximum count and the bin address that reached it
 */
module peakTracker import sifhPkg::*; (
    input  logic                            clk,
    input  logic                            combin_res,
    input  logic                            countStrobe,
    input  logic [COUNT_W-1:0]              countValue,
    input  logic [BIN_W-1:0]                countAddr,
    input  logic [PIXEL_W-1:0]              countPixel,
    input  logic                            passEnd,
    input  logic [PIXEL_W-1:0]              readPixel,
    output logic [BIN_W-1:0]                peakAddr,
    output logic [PIXEL_NUM-1:0][BIN_W-1:0] peakAddrAll
);

    logic [COUNT_W-1:0] maxCount [PIXEL_NUM];
    logic               newMax;

    // Strictly greater, so the first bin to the top count wins
    assign newMax = countStrobe && (countValue > maxCount[countPixel]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                maxCount[p] <= '0;
            end
        end else if (passEnd) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                maxCount[p] <= '0;            // New pass starts empty
            end
        end else if (newMax) begin
            maxCount[countPixel] <= countValue;
        end
    end

    // Addresses survive passEnd for window load and result readout
    always_ff @(posedge clk) begin
        if (newMax) begin
            peakAddrAll[countPixel] <= countAddr;
        end
    end

    assign peakAddr = peakAddrAll[readPixel];

endmodule

//--- windowCalc.sv
/*
 * Window calculation and result assembly
 * Delta per pixel from the coarse peak, fine peak plus delta out
 */
module windowCalc import sifhPkg::*; (
    input  logic                            clk,
    input  logic                            combin_res,
    input  logic                            passEnd,
    input  logic                            pass,
    input  logic [PIXEL_NUM-1:0][BIN_W-1:0] peakAddrAll,
    input  logic [PIXEL_W-1:0]              pixelIdx,
    output logic [SAMPLE_W-1:0]             winLow,
    input  logic [PIXEL_W-1:0]              resultPixel,
    input  logic [BIN_W-1:0]                peakAddr,
    output logic [SAMPLE_W-1:0]             resultPeak
);

    logic [SAMPLE_W-1:0] delta    [PIXEL_NUM];   // Window low edge per pixel
    logic [SAMPLE_W-1:0] binStart [PIXEL_NUM];
    logic [SAMPLE_W-1:0] newDelta [PIXEL_NUM];

    //**************************************************
    // Clamped window placement
    //**************************************************
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            binStart[p] = {peakAddrAll[p], {COARSE_SHIFT{1'b0}}};   // Coarse bin to code
            if (binStart[p] < SAMPLE_W'(WINDOW_MARGIN)) begin
                newDelta[p] = '0;                                  // Bottom of range
            end else if (binStart[p] > SAMPLE_W'(WINDOW_MAX + WINDOW_MARGIN)) begin
                newDelta[p] = SAMPLE_W'(WINDOW_MAX);               // Window ends at 1023
            end else begin
                newDelta[p] = binStart[p] - SAMPLE_W'(WINDOW_MARGIN);
            end
        end
    end

    // Loaded once per frame at the coarse pass end
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                delta[p] <= '0;
            end
        end else if (passEnd && (pass == PASS_COARSE)) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                delta[p] <= newDelta[p];
            end
        end
    end

    assign winLow     = delta[pixelIdx];                              // Fine pass filter
    assign resultPeak = delta[resultPixel] + SAMPLE_W'(peakAddr);     // Back to full scale

endmodule

//--- sifhTop.sv
/*
 * Top level of the two-pass histogram peak finder
 * Sequencer, filter, histogram, tracker and window stages
 */
module sifhTop import sifhPkg::*; (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                sampleReq,
    input  logic [SAMPLE_W-1:0] sample,
    output logic                sampleAck,
    output logic                resultReq,
    output logic [PIXEL_W-1:0]  resultPixel,
    output logic [SAMPLE_W-1:0] resultPeak,
    input  logic                resultAck
);

    logic                            sampleTake;
    logic [PIXEL_W-1:0]              pixelIdx;
    logic                            pass;
    logic                            passEnd;
    logic [SAMPLE_W-1:0]             winLow;
    logic                            binStrobe;     // Filter stage
    logic [BIN_W-1:0]                binAddr;
    logic [PIXEL_W-1:0]              binPixel;
    logic                            countStrobe;   // Histogram stage
    logic [COUNT_W-1:0]              countValue;
    logic [BIN_W-1:0]                countAddr;
    logic [PIXEL_W-1:0]              countPixel;
    logic [BIN_W-1:0]                peakAddr;
    logic [PIXEL_NUM-1:0][BIN_W-1:0] peakAddrAll;

    frameControl i_frameControl (
        .clk, .combin_res, .sampleReq, .sampleAck, .resultReq, .resultAck,
        .sampleTake, .pixelIdx, .pass, .passEnd, .resultPixel
    );

    sampleFilter i_sampleFilter (
        .clk, .combin_res, .sampleTake, .sample, .pixelIdx, .pass, .winLow,
        .binStrobe, .binAddr, .binPixel
    );

    histogramRam i_histogramRam (
        .clk, .combin_res, .binStrobe, .binAddr, .binPixel, .passEnd,
        .countStrobe, .countValue, .countAddr, .countPixel
    );

    // Result walk reads the fine peak of the presented pixel
    peakTracker i_peakTracker (
        .clk, .combin_res, .countStrobe, .countValue, .countAddr, .countPixel,
        .passEnd, .readPixel(resultPixel), .peakAddr, .peakAddrAll
    );

    windowCalc i_windowCalc (
        .clk, .combin_res, .passEnd, .pass, .peakAddrAll, .pixelIdx, .winLow,
        .resultPixel, .peakAddr, .resultPeak
    );

endmodule

//--- sifh_checker.sv
/*
 * Handshake assertions for the frame sequencer
 * Bound into frameControl, failures counted for the testbench summary
 */
module sifh_checker import sifhPkg::*; (
    input logic               clk,
    input logic               combin_res,
    input logic               sampleReq,
    input logic               sampleAck,
    input logic               resultReq,
    input logic               resultAck,
    input logic [PIXEL_W-1:0] resultPixel,
    input logic [1:0]         phase
);

    localparam logic [1:0] RESULT_PHASE = 2'd2;   // RESULTS in the sequencer enum

    int assertFails = 0;

    //**************************************************
    // Input handshake
    //**************************************************
    ackNeedsReq: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(sampleAck) |-> $past(sampleReq))
        else begin
            assertFails++;
            $error("sampleAck rose without a pending sampleReq");
        end

    noAckInResults: assert property (@(posedge clk) disable iff (!combin_res)
        (phase == RESULT_PHASE) |-> !sampleAck)
        else begin
            assertFails++;
            $error("sampleAck high during the result phase");
        end

    //**************************************************
    // Output handshake
    //**************************************************
    reqHolds: assert property (@(posedge clk) disable iff (!combin_res)
        (resultReq && !resultAck) |=> resultReq)
        else begin
            assertFails++;
            $error("resultReq dropped before resultAck");
        end

    pixelStable: assert property (@(posedge clk) disable iff (!combin_res)
        resultReq |=> (!resultReq || $stable(resultPixel)))
        else begin
            assertFails++;
            $error("resultPixel changed while resultReq was high");
        end

endmodule

bind frameControl sifh_checker i_sifhChecker (
    .clk(clk),
    .combin_res(combin_res),
    .sampleReq(sampleReq),
    .sampleAck(sampleAck),
    .resultReq(resultReq),
    .resultAck(resultAck),
    .resultPixel(resultPixel),
    .phase(phase)
);

//--- sifhMonitor.sv
/*
 * Result side of the testbench
 * Answers the result handshake, compares peaks, per-frame lines
 */
module sifhMonitor import sifhPkg::*; (
    input  logic                                  clk,
    input  logic                                  combin_res,
    input  logic                                  sampleAck,
    input  logic                                  resultReq,
    input  logic [PIXEL_W-1:0]                    resultPixel,
    input  logic [SAMPLE_W-1:0]                   resultPeak,
    output logic                                  resultAck,
    input  logic [3*PIXEL_NUM-1:0][SAMPLE_W-1:0]  expectedPeak,
    output int                                    resultCount,
    output int                                    errorCount
);

    localparam int FRAME_NUM   = 3;
    localparam int RESULT_NUM  = FRAME_NUM * PIXEL_NUM;
    localparam int DRIVE_DELAY = 2;
    localparam int ACK_DELAY   = 2;     // Cycles before answering a request

    int frameErrors;

    // One presented result against the vector file
    task automatic checkResult();
        int frame;
        int expPixel;
        frame    = resultCount / PIXEL_NUM;
        expPixel = resultCount % PIXEL_NUM;
        if (resultCount >= RESULT_NUM) begin
            errorCount++;
            $display("unexpected result at %0t: more than %0d results presented",
                     $time, RESULT_NUM);
        end else begin
            if (resultPixel !== PIXEL_W'(expPixel)) begin
                errorCount++;
                frameErrors++;
                $display("mismatch at %0t: frame %0d pixel %0d arrived, pixel %0d expected",
                         $time, frame + 1, resultPixel, expPixel);
            end else if (resultPeak !== expectedPeak[resultCount]) begin
                errorCount++;
                frameErrors++;
                $display("mismatch at %0t: frame %0d pixel %0d peak %0d, expected %0d",
                         $time, frame + 1, expPixel, resultPeak, expectedPeak[resultCount]);
            end
            if (expPixel == PIXEL_NUM - 1) begin
                $display("frame %0d: %0d results checked, %0d errors",
                         frame + 1, PIXEL_NUM, frameErrors);
                frameErrors = 0;
            end
        end
        resultCount++;
    endtask

    initial begin
        resultAck   = 1'b0;
        resultCount = 0;
        errorCount  = 0;
        frameErrors = 0;
        @(posedge combin_res);
        @(negedge clk);                      // Before the first sample edge
        if (sampleAck !== 1'b0 || resultReq !== 1'b0) begin
            errorCount++;
            $display("reset check failed at %0t: handshake outputs not low after reset", $time);
        end
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (resultReq === 1'b1 && !resultAck) begin
                checkResult();
                repeat (ACK_DELAY) @(posedge clk);
                #DRIVE_DELAY;
                resultAck = 1'b1;
                while (resultReq !== 1'b0) begin     // Four-phase return to zero
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                resultAck = 1'b0;
            end
        end
    end

endmodule

//--- sifhTb.sv
/*
 * Testbench top for the SiFH peak finder
 * Clock, reset, LFSR noise, vector file, sample driver, timeout, summary
 */
module sifhTb import sifhPkg::*; ;

    localparam int          FRAME_NUM     = 3;
    localparam int          RESULT_NUM    = FRAME_NUM * PIXEL_NUM;
    localparam int          PERIOD        = 20;
    localparam int          DRIVE_DELAY   = 2;
    localparam int          RESET_CYCLES  = 4;
    localparam int          CENTRE_REPEAT = 3;                    // Rest of burst is noise
    localparam int          FRAME_SAMPLES = 2 * ACQ_NUM * PIXEL_NUM * DATA_NUM;
    localparam int          TIMEOUT_LIMIT = FRAME_NUM * (FRAME_SAMPLES * 6 + 40) + 100;
    localparam logic [31:0] LFSR_SEED     = 32'h038b_81a6;

    logic                                 clk;
    logic                                 combin_res;
    logic                                 sampleReq;
    logic [SAMPLE_W-1:0]                  sample;
    logic                                 sampleAck;
    logic                                 resultReq;
    logic [PIXEL_W-1:0]                   resultPixel;
    logic [SAMPLE_W-1:0]                  resultPeak;
    logic                                 resultAck;
    logic [SAMPLE_W-1:0]                  vectorMem [2*RESULT_NUM];   // Centre, peak pairs
    logic [SAMPLE_W-1:0]                  centre [RESULT_NUM];
    logic [RESULT_NUM-1:0][SAMPLE_W-1:0]  expectedPeak;
    logic [31:0]                          lfsrState;
    int                                   resultCount;
    int                                   errorCount;
    int                                   cycleCount = 0;

    sifhTop i_sifhTop (
        .clk, .combin_res, .sampleReq, .sample, .sampleAck,
        .resultReq, .resultPixel, .resultPeak, .resultAck
    );

    sifhMonitor i_sifhMonitor (
        .clk, .combin_res, .sampleAck, .resultReq, .resultPixel, .resultPeak,
        .resultAck, .expectedPeak, .resultCount, .errorCount
    );

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic drawNoise(output logic [SAMPLE_W-1:0] value);
        value = '0;
        for (int b = 0; b < SAMPLE_W; b++) begin
            lfsrState = lfsrNext(lfsrState);                  // One step per bit
            value     = {value[SAMPLE_W-2:0], lfsrState[0]};
        end
    endtask

    task automatic waitCycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Full four-phase transfer of one sample
    task automatic sendSample(input logic [SAMPLE_W-1:0] value);
        sample    = value;
        sampleReq = 1'b1;
        do begin
            waitCycle();
        end while (sampleAck !== 1'b1);
        sampleReq = 1'b0;
        do begin
            waitCycle();
        end while (sampleAck !== 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    //**************************************************
    // Watchdog
    //**************************************************
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    //**************************************************
    // Stimulus and summary
    //**************************************************
    initial begin
        logic [SAMPLE_W-1:0] value;
        int                  assertFails;
        combin_res = 1'b0;
        sampleReq  = 1'b0;
        sample     = '0;
        lfsrState  = LFSR_SEED;
        $readmemh("sifh_vectors.txt", vectorMem);
        for (int i = 0; i < RESULT_NUM; i++) begin
            centre[i]       = vectorMem[2*i];
            expectedPeak[i] = vectorMem[2*i+1];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        combin_res = 1'b1;

        // Coarse then fine pass, same sample order in each
        for (int frame = 0; frame < FRAME_NUM; frame++) begin
            for (int passIdx = 0; passIdx < 2; passIdx++) begin
                for (int acq = 0; acq < ACQ_NUM; acq++) begin
                    for (int pixel = 0; pixel < PIXEL_NUM; pixel++) begin
                        for (int d = 0; d < DATA_NUM; d++) begin
                            if (d < CENTRE_REPEAT) begin
                                value = centre[frame * PIXEL_NUM + pixel];
                            end else begin
                                drawNoise(value);
                            end
                            sendSample(value);
                        end
                    end
                end
            end
        end

        while (resultCount < RESULT_NUM) begin     // Fourth ack ends the last frame
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        assertFails = i_sifhTop.i_frameControl.i_sifhChecker.assertFails;
        $display("summary: %0d results, %0d errors, %0d assertion failures",
                 resultCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0 && resultCount == RESULT_NUM) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sifh_vectors.txt
// centre expected_peak (hex), one line per pixel, pixels 0 to 3 of each frame
// frame 1 mid-range, frame 2 window clamped at 0 and 960, frame 3 mixed
1f4 1f4
0c8 0c8
2bc 2bc
15e 15e
00a 00a
3f8 3f8
017 017
3ff 3ff
3c1 3c1
01f 01f
200 200
0e3 0e3

//--- sifhHistogram.f
sifhPkg.sv
frameControl.sv
sampleFilter.sv
histogramRam.sv
peakTracker.sv
windowCalc.sv
sifhTop.sv
sifh_checker.sv
sifhMonitor.sv
sifhTb.sv

//--- runSim.sh
#!/bin/sh
# Verilator build and run of the SiFH testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sifhTb \
    -f sifhHistogram.f -o simSifh
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/simSifh)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
